//--- rv_core.f
+incdir+include
design/rv_pkg.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_csr.sv
design/rv_exec.sv
design/rv_core.sv
bench/tb_clkgen.sv
bench/tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - include
    files:
      - design/rv_pkg.sv
      - design/rv_decode.sv
      - design/rv_regfile.sv
      - design/rv_alu.sv
      - design/rv_csr.sv
      - design/rv_exec.sv
      - design/rv_core.sv
      - bench/tb_clkgen.sv
      - bench/tb_rv_core.sv

//--- bench/tb_rv_core.sv
`timescale 1ns/100ps
`include "rv_params.svh"

module tb_rv_core;
    import rv_pkg::*;

    localparam int PROG_SLOTS   = 60;
    localparam int HANDLER_WORD = 128;       // RV_TRAP_VECTOR / 4
    localparam int HANDLER_LEN  = 6;
    localparam int DATA_BASE    = 'h400;     // 64-word data window

    logic   clk;
    logic   reset;
    instr_t instruction_i;
    word_t  pc_o;
    logic   interrupt_i;
    logic   interrupt_ack_o;
    word_t  bus_addr_o;
    word_t  bus_write_data_o;
    logic   bus_write_enable_o;
    logic   bus_read_enable_o;
    word_t  bus_read_data_i;

    instr_t   imem [0:255];
    half_t    dmem [0:63];      // Updated by observed DUT stores
    half_t    m_dmem [0:63];    // Model copy
    op_t      p_op [0:255];     // Program description for the model
    reg_idx_t p_rd [0:255];
    reg_idx_t p_rs1 [0:255];
    reg_idx_t p_rs2 [0:255];
    word_t    p_imm [0:255];
    bit       jalr2 [0:255];    // Second word of an addi/jalr pair

    integer seed;
    int     halt_word;
    word_t  halt_pc;
    int     irq_cycle;          // Cycle where interrupt_i rises
    int     cyc;
    int     limit;
    int     st_idx;
    int     ld_idx;
    int     ack_count;
    int     hs_idx;             // Index of the handler store
    bit     irq_dropped;
    word_t  exp_st_addr [$];
    word_t  exp_st_pc [$];
    half_t  exp_st_data [$];
    word_t  exp_ld_addr [$];

    tb_clkgen i_tb_clkgen (.clk_o(clk), .reset_o(reset));

    rv_core i_rv_core (
        .clk(clk), .reset(reset),
        .instruction_i(instruction_i), .pc_o(pc_o),
        .interrupt_i(interrupt_i), .interrupt_ack_o(interrupt_ack_o),
        .bus_addr_o(bus_addr_o), .bus_write_data_o(bus_write_data_o),
        .bus_write_enable_o(bus_write_enable_o), .bus_read_enable_o(bus_read_enable_o),
        .bus_read_data_i(bus_read_data_i)
    );

    function automatic int urand(input int n);
        urand = $unsigned($random(seed)) % n;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            abort_run($sformatf("Fail %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_half(input string name, input half_t exp, input half_t act);
        if (act !== exp) begin
            abort_run($sformatf("Fail %s expected %h actual %h", name, exp, act));
        end
    endtask

    // Forward target that skips the jalr half of a pair
    function automatic int pick_target(input int from);
        int t;
        t = from + 1 + urand(halt_word - from);
        if (jalr2[t]) t++;
        return t;
    endfunction

    // Assemble one word from its description
    function automatic instr_t encode(input int w);
        logic [11:0] wi;
        word_t       im;
        wi = w;
        im = p_imm[w];
        case (p_op[w])
            OP_LUI:   return {im[31:12], p_rd[w], 7'b0110111};
            OP_AUIPC: return {im[31:12], p_rd[w], 7'b0010111};
            OP_ADDI:  return {im[11:0], p_rs1[w], 3'b000, p_rd[w], 7'b0010011};
            OP_SLLI:  return {6'b0, im[5:0], p_rs1[w], 3'b001, p_rd[w], 7'b0010011};
            OP_ADD:   return {7'b0, p_rs2[w], p_rs1[w], 3'b000, p_rd[w], 7'b0110011};
            OP_SUB:   return {7'b0100000, p_rs2[w], p_rs1[w], 3'b000, p_rd[w], 7'b0110011};
            OP_SLT:   return {7'b0, p_rs2[w], p_rs1[w], 3'b010, p_rd[w], 7'b0110011};
            OP_JAL:   return {im[20], im[10:1], im[11], im[19:12], p_rd[w], 7'b1101111};
            OP_JALR:  return {im[11:0], p_rs1[w], 3'b000, p_rd[w], 7'b1100111};
            OP_BEQ:   return {im[12], im[10:5], p_rs2[w], p_rs1[w], 3'b000, im[4:1], im[11],
                              7'b1100011};
            OP_LW:    return {im[11:0], p_rs1[w], 3'b010, p_rd[w], 7'b0000011};
            OP_SW:    return {im[11:5], p_rs2[w], p_rs1[w], 3'b010, im[4:0], 7'b0100011};
            OP_MRET:  return 32'h3020_0073;
            default:  return {wi, 5'd0, 3'b000, 5'd0, 7'b0010011};  // addi x0 tagged by address
        endcase
    endfunction

    task automatic build_program();
        int          w;
        int          s;
        int          t;
        logic [31:0] r;
        reg_idx_t    rt;
        for (w = 0; w < 256; w++) begin
            p_op[w] = OP_NONE;
            jalr2[w] = 1'b0;
        end
        // Pass 1 picks the kinds only
        w = 0;
        for (s = 0; s < PROG_SLOTS; s++) begin
            case (urand(12))
                0: p_op[w] = OP_LUI;
                1: p_op[w] = OP_AUIPC;
                2: p_op[w] = OP_ADDI;
                3: p_op[w] = OP_SLLI;
                4: p_op[w] = OP_ADD;
                5: p_op[w] = OP_SUB;
                6: p_op[w] = OP_SLT;
                7: p_op[w] = OP_JAL;
                8: begin                 // addi rt, x0, target then jalr rd, rt, 0
                    p_op[w] = OP_ADDI;
                    p_op[w + 1] = OP_JALR;
                    jalr2[w + 1] = 1'b1;
                    w++;
                end
                9: p_op[w] = OP_BEQ;
                10: p_op[w] = OP_LW;
                default: p_op[w] = OP_SW;
            endcase
            w++;
        end
        halt_word = w;
        halt_pc = halt_word * 4;
        p_op[w] = OP_JAL;               // jal x0, 0 spins here
        p_rd[w] = '0;
        p_imm[w] = '0;
        // Pass 2 fills the fields on x0..x7
        for (w = 0; w < halt_word; w++) begin
            r = $random(seed);
            case (p_op[w])
                OP_LUI, OP_AUIPC: begin
                    p_rd[w] = urand(8);
                    p_imm[w] = {{32{r[19]}}, r[19:0], 12'b0};
                end
                OP_ADDI: begin
                    if (jalr2[w + 1]) begin
                        rt = 1 + urand(7);
                        t = pick_target(w + 1);
                        p_rd[w] = rt;
                        p_rs1[w] = '0;
                        p_imm[w] = t * 4;
                        p_rd[w + 1] = urand(8);
                        p_rs1[w + 1] = rt;
                        p_imm[w + 1] = '0;
                    end else begin
                        p_rd[w] = urand(8);
                        p_rs1[w] = urand(8);
                        p_imm[w] = {{52{r[11]}}, r[11:0]};
                    end
                end
                OP_SLLI: begin
                    p_rd[w] = urand(8);
                    p_rs1[w] = urand(8);
                    p_imm[w] = urand(64);
                end
                OP_ADD, OP_SUB, OP_SLT: begin
                    p_rd[w] = urand(8);
                    p_rs1[w] = urand(8);
                    p_rs2[w] = urand(8);
                end
                OP_JAL, OP_BEQ: begin
                    p_rd[w] = urand(8);
                    p_rs1[w] = urand(8);
                    p_rs2[w] = urand(8);
                    p_imm[w] = (pick_target(w) - w) * 4;
                end
                OP_LW, OP_SW: begin
                    p_rd[w] = urand(8);
                    p_rs1[w] = '0;          // Absolute address in the window
                    p_rs2[w] = urand(8);
                    p_imm[w] = DATA_BASE + 4 * urand(64);
                end
                default: ;                  // jalr already filled by its addi
            endcase
        end
        // Handler writes x8..x15 only and ends with a store and mret
        for (w = HANDLER_WORD; w < HANDLER_WORD + 4; w++) begin
            case (urand(4))
                0: p_op[w] = OP_ADDI;
                1: p_op[w] = OP_ADD;
                2: p_op[w] = OP_SUB;
                default: p_op[w] = OP_SLLI;
            endcase
            r = $random(seed);
            p_rd[w] = 8 + urand(8);
            p_rs1[w] = urand(16);
            p_rs2[w] = urand(16);
            p_imm[w] = (p_op[w] == OP_SLLI) ? word_t'(r[5:0]) : {{52{r[11]}}, r[11:0]};
        end
        p_op[HANDLER_WORD + 4] = OP_SW;
        p_rs1[HANDLER_WORD + 4] = '0;
        p_rs2[HANDLER_WORD + 4] = 8 + urand(8);
        p_imm[HANDLER_WORD + 4] = DATA_BASE + 4 * urand(64);
        p_op[HANDLER_WORD + 5] = OP_MRET;
        for (w = 0; w < 256; w++) begin
            imem[w] = encode(w);
        end
    endtask

    // ISA model counting cycles only to place the interrupt
    task automatic run_model();
        word_t x [0:31];
        word_t pc;
        word_t next;
        word_t mepc;
        word_t a;
        word_t b;
        word_t res;
        word_t addr;
        int    c;
        int    w;
        int    steps;
        bit    wen;
        bit    mie;
        bit    mpie;
        bit    took;
        bit    back;
        for (w = 0; w < 32; w++) x[w] = '0;
        for (w = 0; w < 64; w++) m_dmem[w] = dmem[w];
        pc = `RV_RESET_PC;
        mepc = '0;
        c = 1;                              // Cycle 0 runs the reset NOP
        steps = 0;
        mie = 1'b1;
        mpie = 1'b0;
        took = 1'b0;
        back = 1'b0;
        while (!(back && pc == halt_pc)) begin
            steps++;
            if (steps > 2000) abort_run("Model never returned to the halt loop");
            if (!took && c >= irq_cycle && mie) begin
                mepc = pc;                  // Skipped instruction reruns after mret
                mpie = mie;
                mie = 1'b0;
                pc = `RV_TRAP_VECTOR;
                c += 2;
                took = 1'b1;
                continue;
            end
            w = pc[9:2];
            a = x[p_rs1[w]];
            b = x[p_rs2[w]];
            next = pc + 4;
            wen = 1'b1;
            res = '0;
            c += 1;
            case (p_op[w])
                OP_LUI:   res = p_imm[w];
                OP_AUIPC: res = pc + p_imm[w];
                OP_ADDI:  res = a + p_imm[w];
                OP_SLLI:  res = a << p_imm[w][5:0];
                OP_ADD:   res = a + b;
                OP_SUB:   res = a - b;
                OP_SLT:   res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                OP_JAL: begin
                    res = pc + 4;
                    next = pc + p_imm[w];
                    c += 1;
                end
                OP_JALR: begin
                    res = pc + 4;
                    next = (a + p_imm[w]) & ~64'd1;
                    c += 1;
                end
                OP_BEQ: begin
                    wen = 1'b0;
                    if (a == b) begin
                        next = pc + p_imm[w];
                        c += 1;
                    end
                end
                OP_LW: begin
                    addr = a + p_imm[w];
                    exp_ld_addr.push_back(addr);
                    res = {{32{m_dmem[addr[7:2]][31]}}, m_dmem[addr[7:2]]};
                    c += 2;                 // Bubble and write pass
                end
                OP_SW: begin
                    wen = 1'b0;
                    addr = a + p_imm[w];
                    exp_st_addr.push_back(addr);
                    exp_st_data.push_back(b[31:0]);
                    exp_st_pc.push_back(pc + 8);   // Fetch two ahead when seen
                    m_dmem[addr[7:2]] = b[31:0];
                    if (pc >= `RV_TRAP_VECTOR) hs_idx = exp_st_addr.size() - 1;
                end
                OP_MRET: begin
                    wen = 1'b0;
                    next = mepc;
                    mie = mpie;
                    mpie = 1'b1;
                    back = 1'b1;
                    c += 1;
                end
                default: wen = 1'b0;
            endcase
            if (wen && p_rd[w] != '0) x[p_rd[w]] = res;
            pc = next;
        end
    endtask

    task automatic check_reset_state();
        check_word("reset pc", `RV_RESET_PC, pc_o);
        if (bus_read_enable_o !== 1'b0 || bus_write_enable_o !== 1'b0
                || interrupt_ack_o !== 1'b0) begin
            abort_run("A bus or acknowledge strobe is not low at reset");
        end
    endtask

    // Registered outputs settle well before 10 ns after the edge
    task automatic observe_outputs();
        if (bus_write_enable_o === 1'b1) begin
            if (st_idx >= exp_st_addr.size()) abort_run("The core made an unexpected store");
            check_word("store address", exp_st_addr[st_idx], bus_addr_o);
            check_half("store data", exp_st_data[st_idx], bus_write_data_o[31:0]);
            check_word("store pc", exp_st_pc[st_idx], pc_o);
            dmem[bus_addr_o[7:2]] = bus_write_data_o[31:0];
            if (st_idx == hs_idx) irq_dropped = 1'b1;   // Handler done so the line drops
            st_idx++;
        end
        if (bus_read_enable_o === 1'b1) begin
            if (ld_idx >= exp_ld_addr.size()) abort_run("The core made an unexpected load");
            check_word("load address", exp_ld_addr[ld_idx], bus_addr_o);
            ld_idx++;
        end
        if (interrupt_ack_o === 1'b1) begin
            ack_count++;
            if (ack_count > 1) abort_run("A second interrupt acknowledge came while MIE was clear");
            check_word("trap pc", `RV_TRAP_VECTOR, pc_o);
        end
    endtask

    task automatic drive_inputs();
        half_t d;
        d = dmem[bus_addr_o[7:2]];
        instruction_i = imem[pc_o[9:2]];
        bus_read_data_i = {~d, d};          // Upper half is junk the core must ignore
        interrupt_i = (cyc >= irq_cycle) && !irq_dropped;
    endtask

    initial begin
        seed = 72001;
        instruction_i = `RV_NOP;
        interrupt_i = 1'b0;
        bus_read_data_i = '0;
        irq_dropped = 1'b0;
        st_idx = 0;
        ld_idx = 0;
        ack_count = 0;
        hs_idx = -1;
        for (int i = 0; i < 64; i++) begin
            dmem[i] = (DATA_BASE + 4 * i) * 32'h9E37_79B9 + 32'h7F4A_7C15;
        end
        build_program();
        irq_cycle = 3 + urand(40);
        run_model();
        limit = 6 * (halt_word + 1 + HANDLER_LEN) + 20;
        repeat (4) begin
            @(posedge clk);
            #10;
            check_reset_state();
        end
        cyc = 0;
        drive_inputs();
        wait (reset === 1'b1);
        check_reset_state();
        while (!(st_idx == exp_st_addr.size() && ld_idx == exp_ld_addr.size()
                && pc_o == halt_pc)) begin
            @(posedge clk);
            #10;
            cyc++;
            if (cyc > limit) abort_run("Timeout, the core did not reach the end of the program");
            observe_outputs();
            drive_inputs();
        end
        if (ack_count != 1) abort_run("The interrupt was not acknowledged exactly once");
        $display("All tests passed");
        $finish;
    end

endmodule

//--- bench/tb_clkgen.sv
`timescale 1ns/100ps

module tb_clkgen (
    output logic clk_o,
    output logic reset_o
);

    // 100 ns period
    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    // Low through four rising edges, released on a falling edge
    initial begin
        reset_o = 1'b0;
        repeat (4) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b1;
    end

endmodule

//--- design/rv_core.sv
`timescale 1ns/100ps

module rv_core (
    input  logic           clk,
    input  logic           reset,
    input  rv_pkg::instr_t instruction_i,
    output rv_pkg::word_t  pc_o,
    input  logic           interrupt_i,
    output logic           interrupt_ack_o,
    output rv_pkg::word_t  bus_addr_o,
    output rv_pkg::word_t  bus_write_data_o,
    output logic           bus_write_enable_o,
    output logic           bus_read_enable_o,
    input  rv_pkg::word_t  bus_read_data_i
);

    rv_pkg::instr_t   ir;
    rv_pkg::op_t      op;
    rv_pkg::reg_idx_t rd;
    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    rv_pkg::word_t    imm;
    rv_pkg::reg_idx_t rf_rs1;       // Gated read indices
    rv_pkg::reg_idx_t rf_rs2;
    rv_pkg::word_t    rdata1;
    rv_pkg::word_t    rdata2;
    rv_pkg::alu_op_t  alu_op;
    rv_pkg::word_t    alu_a;
    rv_pkg::word_t    alu_b;
    rv_pkg::word_t    alu_y;
    logic             rf_we;
    rv_pkg::reg_idx_t rf_rd;
    rv_pkg::word_t    rf_wdata;
    logic             irq_window;
    logic             mret;
    rv_pkg::word_t    epc;
    logic             take_irq;
    rv_pkg::word_t    mepc;

    rv_exec i_rv_exec (
        .clk(clk), .reset(reset),
        .instruction_i(instruction_i), .pc_o(pc_o), .ir_o(ir),
        .op_i(op), .rd_i(rd), .rs1_i(rs1), .rs2_i(rs2), .imm_i(imm),
        .rf_rs1_o(rf_rs1), .rf_rs2_o(rf_rs2), .rdata1_i(rdata1), .rdata2_i(rdata2),
        .alu_op_o(alu_op), .alu_a_o(alu_a), .alu_b_o(alu_b), .alu_y_i(alu_y),
        .rf_we_o(rf_we), .rf_rd_o(rf_rd), .rf_wdata_o(rf_wdata),
        .irq_window_o(irq_window), .mret_o(mret), .epc_o(epc),
        .take_irq_i(take_irq), .mepc_i(mepc),
        .bus_addr_o(bus_addr_o), .bus_write_data_o(bus_write_data_o),
        .bus_write_enable_o(bus_write_enable_o), .bus_read_enable_o(bus_read_enable_o),
        .bus_read_data_i(bus_read_data_i)
    );

    rv_csr i_rv_csr (
        .clk(clk), .reset(reset), .interrupt_i(interrupt_i),
        .irq_window_i(irq_window), .mret_i(mret), .epc_i(epc),
        .take_irq_o(take_irq), .mepc_o(mepc), .interrupt_ack_o(interrupt_ack_o)
    );

    rv_decode i_rv_decode (
        .ir_i(ir), .rd_o(rd), .rs1_o(rs1), .rs2_o(rs2), .imm_o(imm), .op_o(op)
    );

    rv_alu i_rv_alu (.a_i(alu_a), .b_i(alu_b), .op_i(alu_op), .y_o(alu_y));

    rv_regfile i_rv_regfile (
        .clk(clk), .reset(reset),
        .rs1_i(rf_rs1), .rs2_i(rf_rs2), .rdata1_o(rdata1), .rdata2_o(rdata2),
        .we_i(rf_we), .rd_i(rf_rd), .wdata_i(rf_wdata)
    );

endmodule

//--- design/rv_exec.sv
`timescale 1ns/100ps
`include "rv_params.svh"

module rv_exec (
    input  logic             clk,
    input  logic             reset,
    input  rv_pkg::instr_t   instruction_i,   // Word at pc_o
    output rv_pkg::word_t    pc_o,
    output rv_pkg::instr_t   ir_o,
    input  rv_pkg::op_t      op_i,
    input  rv_pkg::reg_idx_t rd_i,
    input  rv_pkg::reg_idx_t rs1_i,
    input  rv_pkg::reg_idx_t rs2_i,
    input  rv_pkg::word_t    imm_i,
    output rv_pkg::reg_idx_t rf_rs1_o,
    output rv_pkg::reg_idx_t rf_rs2_o,
    input  rv_pkg::word_t    rdata1_i,
    input  rv_pkg::word_t    rdata2_i,
    output rv_pkg::alu_op_t  alu_op_o,
    output rv_pkg::word_t    alu_a_o,
    output rv_pkg::word_t    alu_b_o,
    input  rv_pkg::word_t    alu_y_i,
    output logic             rf_we_o,
    output rv_pkg::reg_idx_t rf_rd_o,
    output rv_pkg::word_t    rf_wdata_o,
    output logic             irq_window_o,
    output logic             mret_o,
    output rv_pkg::word_t    epc_o,
    input  logic             take_irq_i,
    input  rv_pkg::word_t    mepc_i,
    output rv_pkg::word_t    bus_addr_o,
    output rv_pkg::word_t    bus_write_data_o,
    output logic             bus_write_enable_o,
    output logic             bus_read_enable_o,
    input  rv_pkg::word_t    bus_read_data_i
);
    import rv_pkg::*;

    word_t  pc_q;          // Fetch address, one ahead of ir_q
    instr_t ir_q;
    logic   bubble_q;      // Flush the wrong fetch after a redirect
    logic   load_pass_q;   // lw replay carries the read data
    word_t  instr_pc;      // Address of ir_q
    word_t  pc_rel;        // jal, beq target and auipc sum
    word_t  load_data;
    word_t  next_pc;
    logic   active;        // ir_q executes this cycle
    logic   taken;
    logic   load_issue;

    assign instr_pc   = pc_q - 64'd4;
    assign pc_rel     = instr_pc + imm_i;
    assign load_data  = {{32{bus_read_data_i[31]}}, bus_read_data_i[31:0]};  // lw sign extension
    assign active     = !take_irq_i && !bubble_q;
    assign load_issue = active && op_i == OP_LW && !load_pass_q;

    assign pc_o = pc_q;
    assign ir_o = ir_q;
    assign epc_o = instr_pc;                          // Unexecuted instruction
    assign irq_window_o = !bubble_q && !load_pass_q;  // No take mid-load or on a flushed word
    assign mret_o = active && op_i == OP_MRET;
    assign rf_rd_o = rd_i;

    // Unused operand ports read x0
    always_comb begin
        rf_rs1_o = '0;
        rf_rs2_o = '0;
        case (op_i)
            OP_ADDI, OP_SLLI, OP_JALR, OP_LW: rf_rs1_o = rs1_i;
            OP_ADD, OP_SUB, OP_SLT, OP_BEQ, OP_SW: begin
                rf_rs1_o = rs1_i;
                rf_rs2_o = rs2_i;
            end
            default: ;
        endcase
    end

    // ALU steering, rs1 + imm by default (addi, lw, sw, jalr)
    always_comb begin
        alu_a_o  = rdata1_i;
        alu_b_o  = imm_i;
        alu_op_o = ALU_ADD;
        case (op_i)
            OP_SLLI: alu_op_o = ALU_SLL;  // shamt in imm low bits
            OP_ADD:  alu_b_o = rdata2_i;
            OP_SUB: begin
                alu_b_o  = rdata2_i;
                alu_op_o = ALU_SUB;
            end
            OP_SLT: begin
                alu_b_o  = rdata2_i;
                alu_op_o = ALU_SLT;
            end
            default: ;
        endcase
    end

    // Writeback source
    always_comb begin
        rf_we_o    = 1'b0;
        rf_wdata_o = alu_y_i;
        case (op_i)
            OP_ADDI, OP_SLLI, OP_ADD, OP_SUB, OP_SLT: rf_we_o = active;
            OP_LUI: begin
                rf_we_o    = active;
                rf_wdata_o = imm_i;
            end
            OP_AUIPC: begin
                rf_we_o    = active;
                rf_wdata_o = pc_rel;
            end
            OP_JAL, OP_JALR: begin
                rf_we_o    = active;
                rf_wdata_o = pc_q;         // Link, instruction address + 4
            end
            OP_LW: begin
                rf_we_o    = active && load_pass_q;  // Second pass only
                rf_wdata_o = load_data;
            end
            default: ;
        endcase
    end

    // Redirect target
    always_comb begin
        taken   = 1'b0;
        next_pc = pc_rel;
        case (op_i)
            OP_JAL:  taken = 1'b1;
            OP_JALR: begin
                taken   = 1'b1;
                next_pc = {alu_y_i[63:1], 1'b0};
            end
            OP_BEQ:  taken = rdata1_i == rdata2_i;
            OP_MRET: begin
                taken   = 1'b1;
                next_pc = mepc_i;
            end
            default: ;
        endcase
    end

    // Priority: interrupt, bubble, instruction
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc_q <= `RV_RESET_PC;
            ir_q <= `RV_NOP;
            bubble_q <= 1'b0;
            load_pass_q <= 1'b0;
            bus_read_enable_o <= 1'b0;
            bus_write_enable_o <= 1'b0;
        end else begin
            ir_q <= instruction_i;
            pc_q <= pc_q + 64'd4;     // Default sequential fetch
            bubble_q <= 1'b0;
            bus_read_enable_o <= 1'b0;
            bus_write_enable_o <= 1'b0;
            if (take_irq_i) begin
                pc_q <= `RV_TRAP_VECTOR;
                bubble_q <= 1'b1;
            end else if (bubble_q) begin
                pc_q <= pc_q + 64'd4;  // Flushed slot, fetch continues
            end else if (op_i == OP_LW) begin
                if (load_issue) begin
                    pc_q <= instr_pc;   // Refetch lw for the write pass
                    bubble_q <= 1'b1;
                    load_pass_q <= 1'b1;
                    bus_read_enable_o <= 1'b1;
                end else begin
                    load_pass_q <= 1'b0;
                end
            end else if (op_i == OP_SW) begin
                bus_write_enable_o <= 1'b1;
            end else if (taken) begin
                pc_q <= next_pc;
                bubble_q <= 1'b1;
            end
        end
    end

    // Bus payload
    always_ff @(posedge clk) begin
        if (load_issue) begin
            bus_addr_o <= alu_y_i;
        end
        if (active && op_i == OP_SW) begin
            bus_addr_o <= alu_y_i;
            bus_write_data_o <= {32'b0, rdata2_i[31:0]};  // Low word only
        end
    end

endmodule

//--- design/rv_csr.sv
`timescale 1ns/100ps
`include "rv_params.svh"

module rv_csr (
    input  logic          clk,
    input  logic          reset,
    input  logic          interrupt_i,    // Machine external interrupt line
    input  logic          irq_window_i,   // Instruction register holds a takeable instruction
    input  logic          mret_i,
    input  rv_pkg::word_t epc_i,          // Address of the instruction being skipped
    output logic          take_irq_o,
    output rv_pkg::word_t mepc_o,
    output logic          interrupt_ack_o
);
    import rv_pkg::*;

    word_t mstatus_q;  // Only MIE and MPIE are live
    word_t mepc_q;

    // Combinational take decision
    assign take_irq_o = interrupt_i && mstatus_q[`RV_MIE_BIT] && irq_window_i;
    assign mepc_o     = mepc_q;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mstatus_q <= '0;
            mstatus_q[`RV_MIE_BIT] <= 1'b1;  // Interrupts enabled out of reset
            mepc_q <= '0;
            interrupt_ack_o <= 1'b0;
        end else begin
            interrupt_ack_o <= take_irq_o;  // One pulse per take
            if (take_irq_o) begin
                mepc_q <= epc_i;
                mstatus_q[`RV_MPIE_BIT] <= mstatus_q[`RV_MIE_BIT];
                mstatus_q[`RV_MIE_BIT] <= 1'b0;  // Mask nesting
            end else if (mret_i) begin
                mstatus_q[`RV_MIE_BIT] <= mstatus_q[`RV_MPIE_BIT];
                mstatus_q[`RV_MPIE_BIT] <= 1'b1;
            end
        end
    end

endmodule

//--- design/rv_alu.sv
`timescale 1ns/100ps

module rv_alu (
    input  rv_pkg::word_t   a_i,
    input  rv_pkg::word_t   b_i,
    input  rv_pkg::alu_op_t op_i,
    output rv_pkg::word_t   y_o
);
    import rv_pkg::*;

    logic [5:0] shamt;
    logic       lt;

    assign shamt = b_i[5:0];                   // RV64 shift amount
    assign lt    = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (op_i)
            ALU_ADD: y_o = a_i + b_i;
            ALU_SUB: y_o = a_i - b_i;
            ALU_SLT: y_o = {63'b0, lt};
            ALU_SLL: y_o = a_i << shamt;
            default: y_o = a_i + b_i;
        endcase
    end

endmodule

//--- design/rv_regfile.sv
`timescale 1ns/100ps

module rv_regfile (
    input  logic             clk,
    input  logic             reset,
    input  rv_pkg::reg_idx_t rs1_i,
    input  rv_pkg::reg_idx_t rs2_i,
    output rv_pkg::word_t    rdata1_o,
    output rv_pkg::word_t    rdata2_o,
    input  logic             we_i,
    input  rv_pkg::reg_idx_t rd_i,
    input  rv_pkg::word_t    wdata_i
);
    import rv_pkg::*;

    word_t regs [1:31];  // No storage for x0

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin  // x0 writes dropped
            regs[rd_i] <= wdata_i;
        end
    end

    // Combinational reads, x0 hardwired
    assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

//--- design/rv_decode.sv
`timescale 1ns/100ps

module rv_decode (
    input  rv_pkg::instr_t   ir_i,
    output rv_pkg::reg_idx_t rd_o,
    output rv_pkg::reg_idx_t rs1_o,
    output rv_pkg::reg_idx_t rs2_o,
    output rv_pkg::word_t    imm_o,
    output rv_pkg::op_t      op_o
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = ir_i[6:0];
    assign funct3 = ir_i[14:12];
    assign funct7 = ir_i[31:25];

    assign rd_o  = ir_i[11:7];
    assign rs1_o = ir_i[19:15];
    assign rs2_o = ir_i[24:20];

    // Immediate select by format
    always_comb begin
        case (opcode)
            7'b0110111, 7'b0010111: imm_o = {{32{ir_i[31]}}, ir_i[31:12], 12'b0};  // U lui auipc
            7'b0100011: imm_o = {{52{ir_i[31]}}, ir_i[31:25], ir_i[11:7]};          // S sw
            7'b1101111: imm_o = {{43{ir_i[31]}}, ir_i[31], ir_i[19:12], ir_i[20],
                                 ir_i[30:21], 1'b0};                               // J jal
            7'b1100011: imm_o = {{51{ir_i[31]}}, ir_i[31], ir_i[7], ir_i[30:25],
                                 ir_i[11:8], 1'b0};                                // B beq
            default:    imm_o = {{52{ir_i[31]}}, ir_i[31:20]};  // I, low 6 bits are shamt
        endcase
    end

    // Operation class
    always_comb begin
        op_o = OP_NONE;
        case (opcode)
            7'b0110111: op_o = OP_LUI;
            7'b0010111: op_o = OP_AUIPC;
            7'b0010011: begin
                if (funct3 == 3'b000) op_o = OP_ADDI;
                else if (funct3 == 3'b001 && ir_i[31:26] == 6'b0) op_o = OP_SLLI;  // RV64 shamt
            end
            7'b0110011: begin
                if (funct7 == 7'b0000000 && funct3 == 3'b000) op_o = OP_ADD;
                else if (funct7 == 7'b0100000 && funct3 == 3'b000) op_o = OP_SUB;
                else if (funct7 == 7'b0000000 && funct3 == 3'b010) op_o = OP_SLT;
            end
            7'b1101111: op_o = OP_JAL;
            7'b1100111: if (funct3 == 3'b000) op_o = OP_JALR;
            7'b1100011: if (funct3 == 3'b000) op_o = OP_BEQ;
            7'b0000011: if (funct3 == 3'b010) op_o = OP_LW;
            7'b0100011: if (funct3 == 3'b010) op_o = OP_SW;
            7'b1110011: if (ir_i == 32'h3020_0073) op_o = OP_MRET;  // Exact mret word
            default: op_o = OP_NONE;
        endcase
    end

endmodule

//--- design/rv_pkg.sv
package rv_pkg;

    // Register or address value
    typedef logic [63:0] word_t;

    // Memory data item, low half of a word
    typedef logic [31:0] half_t;

    typedef logic [4:0]  reg_idx_t;   // x0..x31
    typedef logic [31:0] instr_t;     // Raw instruction word

    // Operation classes the core executes
    typedef enum logic [3:0] {
        OP_LUI,
        OP_AUIPC,
        OP_ADDI,
        OP_SLLI,
        OP_ADD,
        OP_SUB,
        OP_SLT,
        OP_JAL,
        OP_JALR,
        OP_BEQ,
        OP_LW,
        OP_SW,
        OP_MRET,
        OP_NONE     // Unknown encoding, runs as no-op
    } op_t;

    // ALU functions
    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,    // Signed compare
        ALU_SLL
    } alu_op_t;

endpackage

//--- include/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// First fetch address after reset
`define RV_RESET_PC     64'h0000_0000_0000_0000

// Fixed machine trap vector, no writable mtvec
`define RV_TRAP_VECTOR  64'h0000_0000_0000_0200

// addi x0, x0, 0 held in the instruction register after reset
`define RV_NOP          32'h0000_0013

// Interrupt bit set, code 11 machine external interrupt
`define RV_CAUSE_MEI    64'h8000_0000_0000_000B

`define RV_MIE_BIT      3   // mstatus.MIE
`define RV_MPIE_BIT     7   // mstatus.MPIE

`endif
